// ==== chacha_pkg.sv ====
/*
 * Shared definitions for the ChaCha20 block engine.
 * Holds the host address map, the control and status bit positions,
 * the cipher constants and the block controller state type.
 * RTL modules import it inside their bodies; the testbench imports it
 * for addresses and constants.
 */
`default_nettype none

package chacha_pkg;

    // --------------------
    // Widths and sizes
    // --------------------
    localparam int word_width  = 32;
    localparam int block_words = 16;
    localparam int key_words   = 8;
    localparam int iv_words    = 2;
    localparam int addr_width  = 8;

    // Host address map, each window as long as its word count
    localparam logic [addr_width-1:0] addr_ctrl          = 8'h08;
    localparam logic [addr_width-1:0] addr_status        = 8'h09;
    localparam logic [addr_width-1:0] addr_key_base      = 8'h10;
    localparam logic [addr_width-1:0] addr_iv_base       = 8'h20;
    localparam logic [addr_width-1:0] addr_data_in_base  = 8'h40;
    localparam logic [addr_width-1:0] addr_data_out_base = 8'h80;

    // Control and status bit positions
    localparam int ctrl_init_bit    = 0;
    localparam int ctrl_next_bit    = 1;
    localparam int status_ready_bit = 0;
    localparam int status_valid_bit = 1;

    // --------------------
    // Cipher constants
    // --------------------
    localparam logic [word_width-1:0] sigma_words [4] = '{
        32'h61707865, 32'h3320646e, 32'h79622d32, 32'h6b206574
    };
    localparam int double_rounds = 10;

    typedef enum logic [2:0] {idle, load, rounds, finalize, done} ctrl_state_t;

endpackage

`default_nettype wire

// ==== chacha_quarter_round.sv ====
/*
 * ChaCha quarter round on four 32-bit words.
 * Purely combinational add, XOR and rotate chain with rotations of
 * 16, 12, 8 and 7. The block core runs four of these in parallel.
 */
`default_nettype none

module chacha_quarter_round (
    input  logic [chacha_pkg::word_width-1:0] a,
    input  logic [chacha_pkg::word_width-1:0] b,
    input  logic [chacha_pkg::word_width-1:0] c,
    input  logic [chacha_pkg::word_width-1:0] d,
    output logic [chacha_pkg::word_width-1:0] a_out,
    output logic [chacha_pkg::word_width-1:0] b_out,
    output logic [chacha_pkg::word_width-1:0] c_out,
    output logic [chacha_pkg::word_width-1:0] d_out
);
    import chacha_pkg::*;

    function automatic logic [word_width-1:0] rotl(input logic [word_width-1:0] x, input int n);
        return (x << n) | (x >> (word_width - n));
    endfunction

    always_comb begin : qr_steps
        logic [word_width-1:0] a0, a1, b0, b1, c0, c1, d0, d1;
        a0 = a + b;
        d0 = rotl(d ^ a0, 16);
        c0 = c + d0;
        b0 = rotl(b ^ c0, 12);
        a1 = a0 + b0;
        d1 = rotl(d0 ^ a1, 8);
        c1 = c0 + d1;
        b1 = rotl(b0 ^ c1, 7);
        a_out = a1;
        b_out = b1;
        c_out = c1;
        d_out = d1;
    end

endmodule

`default_nettype wire

// ==== chacha_block_core.sv ====
/*
 * ChaCha20 block core with a fixed 20 rounds and a 64-bit block counter.
 * An init pulse starts a block at counter 0, a next pulse in done starts
 * the following block. Each round cycle runs one column or diagonal step
 * through four parallel quarter rounds. ready and data_valid rise together
 * with the output words, 23 cycles after the start pulse.
 */
`default_nettype none

module chacha_block_core (
    input  logic                                                     clk,
    input  logic                                                     reset_n,
    input  logic                                                     init,
    input  logic                                                     next,
    input  logic [chacha_pkg::key_words*chacha_pkg::word_width-1:0]   key_words,
    input  logic [chacha_pkg::iv_words*chacha_pkg::word_width-1:0]    iv_words,
    input  logic [chacha_pkg::block_words*chacha_pkg::word_width-1:0] data_in_words,
    output logic                                                     ready,
    output logic                                                     data_valid,
    output logic [chacha_pkg::block_words*chacha_pkg::word_width-1:0] data_out_words
);
    import chacha_pkg::*;

    typedef logic [$clog2(double_rounds)-1:0] dr_count_t;

    ctrl_state_t               ctrl_state;
    logic                      half_round;
    dr_count_t                 dr_ctr;
    logic [2*word_width-1:0]   block_ctr;

    logic [word_width-1:0]     init_word  [block_words];
    logic [word_width-1:0]     state_reg  [block_words];
    logic [word_width-1:0]     state_next [block_words];
    logic [word_width-1:0]     qr_in  [4][4];
    logic [word_width-1:0]     qr_out [4][4];
    logic [block_words*word_width-1:0] block_out;

    function automatic logic [word_width-1:0] byte_rev(input logic [word_width-1:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // Quarter round q takes column q on the column step, shifted right by row on diagonals
    function automatic int word_index(input int q, input int r, input logic diag);
        return 4 * r + ((q + (diag ? r : 0)) % 4);
    endfunction

    // --------------------
    // Initial state matrix
    // --------------------
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            init_word[i] = sigma_words[i];
        end
        // Key register 7 lands in word 4
        for (int k = 0; k < chacha_pkg::key_words; k++) begin
            init_word[4 + k] =
                byte_rev(key_words[(chacha_pkg::key_words - 1 - k) * word_width +: word_width]);
        end
        init_word[12] = block_ctr[word_width-1:0];
        init_word[13] = block_ctr[2*word_width-1:word_width];
        for (int j = 0; j < chacha_pkg::iv_words; j++) begin
            init_word[14 + j] = byte_rev(iv_words[j * word_width +: word_width]);
        end
    end

    // --------------------
    // Round datapath
    // --------------------
    always_comb begin
        for (int q = 0; q < 4; q++) begin
            for (int r = 0; r < 4; r++) begin
                qr_in[q][r] = state_reg[word_index(q, r, half_round)];
            end
        end
    end

    for (genvar q = 0; q < 4; q++) begin : g_qr
        chacha_quarter_round i_qr (
            .a     (qr_in[q][0]),
            .b     (qr_in[q][1]),
            .c     (qr_in[q][2]),
            .d     (qr_in[q][3]),
            .a_out (qr_out[q][0]),
            .b_out (qr_out[q][1]),
            .c_out (qr_out[q][2]),
            .d_out (qr_out[q][3])
        );
    end

    always_comb begin
        state_next = state_reg;
        if (ctrl_state == load) begin
            state_next = init_word;
        end else if (ctrl_state == rounds) begin
            for (int q = 0; q < 4; q++) begin
                for (int r = 0; r < 4; r++) begin
                    state_next[word_index(q, r, half_round)] = qr_out[q][r];
                end
            end
        end
    end

    // Keystream word is the byte-reversed sum of initial and final state
    always_comb begin
        for (int j = 0; j < block_words; j++) begin
            block_out[j*word_width +: word_width] = data_in_words[j*word_width +: word_width]
                ^ byte_rev(init_word[j] + state_reg[j]);
        end
    end

    always_ff @(posedge clk) begin
        state_reg <= state_next;
        if (ctrl_state == finalize) begin
            data_out_words <= block_out;
        end
    end

    // --------------------
    // Controller
    // --------------------
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            ctrl_state <= idle;
            ready      <= 1'b1;
            data_valid <= 1'b0;
            half_round <= 1'b0;
            dr_ctr     <= '0;
            block_ctr  <= '0;
        end else begin
            case (ctrl_state)
                idle, done: begin
                    // init wins over next; next only continues a finished block
                    if (init || (next && ctrl_state == done)) begin
                        block_ctr  <= init ? '0 : block_ctr + 1'b1;
                        ready      <= 1'b0;
                        data_valid <= 1'b0;
                        ctrl_state <= load;
                    end
                end
                load: begin
                    half_round <= 1'b0;
                    dr_ctr     <= '0;
                    ctrl_state <= rounds;
                end
                rounds: begin
                    half_round <= ~half_round;
                    if (half_round) begin
                        if (dr_ctr == dr_count_t'(double_rounds - 1)) begin
                            dr_ctr     <= '0;
                            ctrl_state <= finalize;
                        end else begin
                            dr_ctr <= dr_ctr + 1'b1;
                        end
                    end
                end
                finalize: begin
                    ready      <= 1'b1;
                    data_valid <= 1'b1;
                    ctrl_state <= done;
                end
                default: ctrl_state <= idle;
            endcase
        end
    end

    a_valid_implies_ready: assert property (
        @(posedge clk) disable iff (!reset_n) data_valid |-> ready);

    a_dr_ctr_range: assert property (
        @(posedge clk) disable iff (!reset_n) dr_ctr <= dr_count_t'(double_rounds - 1));

endmodule

`default_nettype wire

// ==== chacha_reg_bank.sv ====
/*
 * Host register file for the ChaCha20 engine.
 * Decodes the 32-bit register port, stores key, IV and input data words,
 * and turns control writes into one-cycle init and next pulses.
 * Reads return ctrl, status, key, IV and output words in the same cycle;
 * unmapped addresses read 0.
 */
`default_nettype none

module chacha_reg_bank (
    input  logic                                                     clk,
    input  logic                                                     reset_n,
    input  logic                                                     cs,
    input  logic                                                     we,
    input  logic [chacha_pkg::addr_width-1:0]                        addr,
    input  logic [chacha_pkg::word_width-1:0]                        write_data,
    input  logic                                                     ready,
    input  logic                                                     data_valid,
    input  logic [chacha_pkg::block_words*chacha_pkg::word_width-1:0] data_out_words,
    output logic [chacha_pkg::word_width-1:0]                        read_data,
    output logic                                                     init,
    output logic                                                     next,
    output logic [chacha_pkg::key_words*chacha_pkg::word_width-1:0]   key_words,
    output logic [chacha_pkg::iv_words*chacha_pkg::word_width-1:0]    iv_words,
    output logic [chacha_pkg::block_words*chacha_pkg::word_width-1:0] data_in_words
);
    import chacha_pkg::*;

    logic write_en;
    logic read_en;

    assign write_en = cs && we;
    assign read_en  = cs && !we;

    // Word at offset within the window starting at base
    function automatic logic hit(input logic [addr_width-1:0] a,
                                 input logic [addr_width-1:0] base, input int offset);
        return a == base + addr_width'(offset);
    endfunction

    // --------------------
    // Write side
    // --------------------
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            init          <= 1'b0;
            next          <= 1'b0;
            key_words     <= '0;
            iv_words      <= '0;
            data_in_words <= '0;
        end else begin
            // Pulses stay high for the single cycle after the ctrl write
            init <= write_en && addr == addr_ctrl && write_data[ctrl_init_bit];
            next <= write_en && addr == addr_ctrl && write_data[ctrl_next_bit];
            for (int k = 0; k < chacha_pkg::key_words; k++) begin
                if (write_en && hit(addr, addr_key_base, k)) begin
                    key_words[k*word_width +: word_width] <= write_data;
                end
            end
            for (int j = 0; j < chacha_pkg::iv_words; j++) begin
                if (write_en && hit(addr, addr_iv_base, j)) begin
                    iv_words[j*word_width +: word_width] <= write_data;
                end
            end
            for (int j = 0; j < block_words; j++) begin
                if (write_en && hit(addr, addr_data_in_base, j)) begin
                    data_in_words[j*word_width +: word_width] <= write_data;
                end
            end
        end
    end

    // --------------------
    // Read multiplexer
    // --------------------
    always_comb begin
        read_data = '0;
        if (read_en) begin
            if (addr == addr_ctrl) begin
                read_data[ctrl_init_bit] = init;
                read_data[ctrl_next_bit] = next;
            end
            if (addr == addr_status) begin
                read_data[status_ready_bit] = ready;
                read_data[status_valid_bit] = data_valid;
            end
            for (int k = 0; k < chacha_pkg::key_words; k++) begin
                if (hit(addr, addr_key_base, k)) begin
                    read_data = key_words[k*word_width +: word_width];
                end
            end
            for (int j = 0; j < chacha_pkg::iv_words; j++) begin
                if (hit(addr, addr_iv_base, j)) begin
                    read_data = iv_words[j*word_width +: word_width];
                end
            end
            // Input data is write-only
            for (int j = 0; j < block_words; j++) begin
                if (hit(addr, addr_data_out_base, j)) begin
                    read_data = data_out_words[j*word_width +: word_width];
                end
            end
        end
    end

    a_init_single_cycle: assert property (
        @(posedge clk) disable iff (!reset_n) init |=> !init);

    a_next_single_cycle: assert property (
        @(posedge clk) disable iff (!reset_n) next |=> !next);

endmodule

`default_nettype wire

// ==== chacha_top.sv ====
/*
 * Top level of the ChaCha20 block engine.
 * Joins the host register bank to the block core; the host sees only
 * the 32-bit register port.
 */
`default_nettype none

module chacha_top (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic                              cs,
    input  logic                              we,
    input  logic [chacha_pkg::addr_width-1:0] addr,
    input  logic [chacha_pkg::word_width-1:0] write_data,
    output logic [chacha_pkg::word_width-1:0] read_data
);
    import chacha_pkg::*;

    logic                              init;
    logic                              next;
    logic                              ready;
    logic                              data_valid;
    logic [key_words*word_width-1:0]   key_vec;
    logic [iv_words*word_width-1:0]    iv_vec;
    logic [block_words*word_width-1:0] data_in_vec;
    logic [block_words*word_width-1:0] data_out_vec;

    chacha_reg_bank i_reg_bank (
        .clk            (clk),
        .reset_n        (reset_n),
        .cs             (cs),
        .we             (we),
        .addr           (addr),
        .write_data     (write_data),
        .ready          (ready),
        .data_valid     (data_valid),
        .data_out_words (data_out_vec),
        .read_data      (read_data),
        .init           (init),
        .next           (next),
        .key_words      (key_vec),
        .iv_words       (iv_vec),
        .data_in_words  (data_in_vec)
    );

    chacha_block_core i_block_core (
        .clk            (clk),
        .reset_n        (reset_n),
        .init           (init),
        .next           (next),
        .key_words      (key_vec),
        .iv_words       (iv_vec),
        .data_in_words  (data_in_vec),
        .ready          (ready),
        .data_valid     (data_valid),
        .data_out_words (data_out_vec)
    );

endmodule

`default_nettype wire

// ==== chacha_ref_model.svh ====
/*
 * Reference ChaCha20 block model for the testbench.
 * Builds the state from key and IV words in register order and a 64-bit
 * block counter, runs 20 rounds, and returns input data XOR keystream.
 * Included inside the testbench module body.
 */
`ifndef chacha_ref_model_svh
`define chacha_ref_model_svh
`default_nettype none

function automatic logic [31:0] model_rotl(input logic [31:0] v, input int s);
    return (v << s) | (v >> (32 - s));
endfunction

function automatic logic [31:0] model_bswap(input logic [31:0] v);
    return {v[7:0], v[15:8], v[23:16], v[31:24]};
endfunction

// Word j of the result sits at bits j*32 upward, as in the data_out window
function automatic logic [511:0] model_block(input logic [255:0] key,
                                             input logic [63:0]  iv,
                                             input logic [63:0]  ctr,
                                             input logic [511:0] data);
    // Four column groups, then four diagonal groups
    int           qi [8][4] = '{'{0, 4, 8, 12}, '{1, 5, 9, 13}, '{2, 6, 10, 14},
                                '{3, 7, 11, 15}, '{0, 5, 10, 15}, '{1, 6, 11, 12},
                                '{2, 7, 8, 13}, '{3, 4, 9, 14}};
    logic [31:0]  x0 [16];
    logic [31:0]  x [16];
    logic [31:0]  a, b, c, d;
    logic [511:0] result;
    for (int i = 0; i < 4; i++) begin
        x0[i] = chacha_pkg::sigma_words[i];
    end
    // Key register 7 is the first key word of the matrix
    for (int k = 0; k < 8; k++) begin
        x0[4 + k] = model_bswap(key[(7 - k) * 32 +: 32]);
    end
    x0[12] = ctr[31:0];
    x0[13] = ctr[63:32];
    x0[14] = model_bswap(iv[31:0]);
    x0[15] = model_bswap(iv[63:32]);
    x = x0;
    for (int dr = 0; dr < 10; dr++) begin
        for (int g = 0; g < 8; g++) begin
            a = x[qi[g][0]];
            b = x[qi[g][1]];
            c = x[qi[g][2]];
            d = x[qi[g][3]];
            a = a + b;
            d = model_rotl(d ^ a, 16);
            c = c + d;
            b = model_rotl(b ^ c, 12);
            a = a + b;
            d = model_rotl(d ^ a, 8);
            c = c + d;
            b = model_rotl(b ^ c, 7);
            x[qi[g][0]] = a;
            x[qi[g][1]] = b;
            x[qi[g][2]] = c;
            x[qi[g][3]] = d;
        end
    end
    for (int j = 0; j < 16; j++) begin
        result[j * 32 +: 32] = data[j * 32 +: 32] ^ model_bswap(x0[j] + x[j]);
    end
    return result;
endfunction

`default_nettype wire
`endif

// ==== tb_chacha_top.sv ====
/*
 * Testbench for the ChaCha20 block engine.
 * Drives the host register port, checks reset values and key/IV readback,
 * then runs a table of init and next blocks against a reference model.
 * Prints one line per test and a closing summary.
 */
`default_nettype none

module tb_chacha_top;
    timeunit 1ns;
    timeprecision 1ps;
    import chacha_pkg::*;

    typedef enum logic {op_init, op_next} tb_op_t;

    localparam int           ready_timeout = 200;
    localparam int           num_rows      = 7;
    localparam logic [255:0] key_a =
        256'h0001_0203_0405_0607_0809_0a0b_0c0d_0e0f_1011_1213_1415_1617_1819_1a1b_1c1d_1e1f;
    localparam logic [255:0] key_b =
        256'h9a3e_55d0_17bc_40f2_e861_0c7d_3b29_a4e5_5f08_d1c3_6e74_b29a_0df1_8c56_27e3_b4a9;

    // --------------------
    // Test table
    // --------------------
    string        row_name [num_rows] = '{"zero_key_init", "random_init", "next_block_1",
                                          "next_block_2", "reinit_block_0", "new_key_init",
                                          "new_key_next"};
    tb_op_t       row_op [num_rows] = '{op_init, op_init, op_next, op_next, op_init,
                                        op_init, op_next};
    logic [255:0] row_key [num_rows] = '{256'h0, key_a, key_a, key_a, key_a, key_b, key_b};
    logic [63:0]  row_iv [num_rows] = '{64'h0, 64'h0000_004a_0900_0000, 64'h0000_004a_0900_0000,
                                        64'h0000_004a_0900_0000, 64'h0000_004a_0900_0000,
                                        64'h1f2e_3d4c_5b6a_7988, 64'h1f2e_3d4c_5b6a_7988};
    logic         row_rand_data [num_rows] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1};
    logic [63:0]  row_ctr [num_rows] = '{64'd0, 64'd0, 64'd1, 64'd2, 64'd0, 64'd0, 64'd1};

    logic        clk;
    logic        reset_n;
    logic        cs;
    logic        we;
    logic [7:0]  addr;
    logic [31:0] write_data;
    logic [31:0] read_data;

    int error_count = 0;
    int test_count  = 0;
    int fail_tests  = 0;

    `include "chacha_ref_model.svh"

    chacha_top i_chacha_top (
        .clk        (clk),
        .reset_n    (reset_n),
        .cs         (cs),
        .we         (we),
        .addr       (addr),
        .write_data (write_data),
        .read_data  (read_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------
    // Bus tasks
    // --------------------
    task automatic write_reg(input logic [7:0] a, input logic [31:0] v);
        @(negedge clk);
        cs         = 1'b1;
        we         = 1'b1;
        addr       = a;
        write_data = v;
    endtask

    // Sampled in the low clock phase well clear of the rising edge
    task automatic read_reg(input logic [7:0] a, output logic [31:0] v);
        @(negedge clk);
        cs   = 1'b1;
        we   = 1'b0;
        addr = a;
        #1;
        v = read_data;
    endtask

    task automatic bus_idle();
        @(negedge clk);
        cs = 1'b0;
        we = 1'b0;
    endtask

    task automatic compare_word(input string name, input string what,
                                input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("Error: %s %s expected %08h actual %08h", name, what, exp, act);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_count++;
        if (error_count == errs_before) begin
            $display("PASS %s", name);
        end else begin
            fail_tests++;
            $display("FAIL %s", name);
        end
    endtask

    task automatic wait_ready(input string name, output logic ok, output logic [31:0] st);
        ok = 1'b0;
        st = '0;
        for (int i = 0; i < ready_timeout && !ok; i++) begin
            read_reg(addr_status, st);
            ok = st[status_ready_bit];
        end
        if (!ok) begin
            $display("%s: core did not raise ready within %0d status polls", name, ready_timeout);
            error_count++;
        end
    endtask

    function automatic logic [31:0] fill_word(input logic [7:0] a);
        return {a, ~a, a ^ 8'h5a, a + 8'h33};
    endfunction

    // --------------------
    // Tests
    // --------------------
    task automatic check_reset_state();
        logic [31:0] rd;
        logic [31:0] exp_status;
        logic [7:0]  unmapped [3];
        int          errs_before;
        errs_before = error_count;
        exp_status = '0;
        exp_status[status_ready_bit] = 1'b1;
        unmapped = '{8'h05, 8'h30, 8'h90};
        read_reg(addr_status, rd);
        compare_word("reset_state", "status", exp_status, rd);
        read_reg(addr_ctrl, rd);
        compare_word("reset_state", "ctrl", 32'h0, rd);
        for (int k = 0; k < 8; k++) begin
            read_reg(addr_key_base + 8'(k), rd);
            compare_word("reset_state", $sformatf("key[%0d]", k), 32'h0, rd);
        end
        for (int j = 0; j < 2; j++) begin
            read_reg(addr_iv_base + 8'(j), rd);
            compare_word("reset_state", $sformatf("iv[%0d]", j), 32'h0, rd);
        end
        for (int u = 0; u < 3; u++) begin
            read_reg(unmapped[u], rd);
            compare_word("reset_state", $sformatf("addr %02h", unmapped[u]), 32'h0, rd);
        end
        finish_test("reset_state", errs_before);
    endtask

    task automatic check_readback();
        logic [31:0] rd;
        logic [7:0]  a;
        int          errs_before;
        errs_before = error_count;
        for (int k = 0; k < 10; k++) begin
            a = (k < 8) ? addr_key_base + 8'(k) : addr_iv_base + 8'(k - 8);
            write_reg(a, fill_word(a));
        end
        for (int k = 0; k < 10; k++) begin
            a = (k < 8) ? addr_key_base + 8'(k) : addr_iv_base + 8'(k - 8);
            read_reg(a, rd);
            compare_word("key_iv_readback", $sformatf("addr %02h", a), fill_word(a), rd);
        end
        // Input data window holds a value but reads back 0
        write_reg(addr_data_in_base, fill_word(addr_data_in_base));
        read_reg(addr_data_in_base, rd);
        compare_word("key_iv_readback", "data_in[0]", 32'h0, rd);
        finish_test("key_iv_readback", errs_before);
    endtask

    task automatic run_row(input int r);
        logic [511:0] data;
        logic [511:0] expected;
        logic [31:0]  rd;
        logic [31:0]  start;
        logic [31:0]  done_status;
        logic         ok;
        int           errs_before;
        errs_before = error_count;
        for (int j = 0; j < 16; j++) begin
            data[j * 32 +: 32] = row_rand_data[r] ? $urandom : 32'h0;
        end
        for (int k = 0; k < 8; k++) begin
            write_reg(addr_key_base + 8'(k), row_key[r][k * 32 +: 32]);
        end
        for (int j = 0; j < 2; j++) begin
            write_reg(addr_iv_base + 8'(j), row_iv[r][j * 32 +: 32]);
        end
        for (int j = 0; j < 16; j++) begin
            write_reg(addr_data_in_base + 8'(j), data[j * 32 +: 32]);
        end
        start = '0;
        start[(row_op[r] == op_init) ? ctrl_init_bit : ctrl_next_bit] = 1'b1;
        write_reg(addr_ctrl, start);
        bus_idle();
        // Pulse has reached the core, so it is busy now
        read_reg(addr_status, rd);
        compare_word(row_name[r], "busy status", 32'h0, rd);
        // An extra next while busy leaves the counter alone
        write_reg(addr_ctrl, 32'h1 << ctrl_next_bit);
        wait_ready(row_name[r], ok, rd);
        if (ok) begin
            done_status = (32'h1 << status_ready_bit) | (32'h1 << status_valid_bit);
            compare_word(row_name[r], "done status", done_status, rd);
            expected = model_block(row_key[r], row_iv[r], row_ctr[r], data);
            for (int j = 0; j < 16; j++) begin
                read_reg(addr_data_out_base + 8'(j), rd);
                compare_word(row_name[r], $sformatf("data_out[%0d]", j),
                             expected[j * 32 +: 32], rd);
            end
        end
        finish_test(row_name[r], errs_before);
    endtask

    initial begin
        void'($urandom(32'hddf1_ce7f));
        reset_n    = 1'b0;
        cs         = 1'b0;
        we         = 1'b0;
        addr       = '0;
        write_data = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        check_reset_state();
        check_readback();
        for (int r = 0; r < num_rows; r++) begin
            run_row(r);
        end
        bus_idle();

        $display("Summary: %0d tests, %0d failed, %0d errors", test_count, fail_tests,
                 error_count);
        if (fail_tests == 0 && error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
chacha_pkg.sv
chacha_quarter_round.sv
chacha_block_core.sv
chacha_reg_bank.sv
chacha_top.sv
tb_chacha_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ChaCha20 testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_chacha_top -f project.f
out=$(./obj_dir/Vtb_chacha_top) || true
echo "$out"
if echo "$out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
